// ==== logic/id_defines.svh ====
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Register index fields in the instruction word
`define ID_RS1 19:15
`define ID_RS2 24:20
`define ID_RD  11:7

// Major opcodes of the supported RV32I groups
`define ID_OPC_OP    7'b0110011
`define ID_OPC_OPIMM 7'b0010011
`define ID_OPC_LUI   7'b0110111
`define ID_OPC_AUIPC 7'b0010111
`define ID_OPC_LOAD  7'b0000011
`define ID_OPC_STORE 7'b0100011

// funct3 of the integer ALU group
`define ID_F3_ADD  3'b000
`define ID_F3_SLL  3'b001
`define ID_F3_SLT  3'b010
`define ID_F3_SLTU 3'b011
`define ID_F3_XOR  3'b100
`define ID_F3_SR   3'b101
`define ID_F3_OR   3'b110
`define ID_F3_AND  3'b111
// Only memory width accepted
`define ID_F3_WORD 3'b010

// ALU operation codes seen by execute
`define ID_ALU_ADD  4'd0
`define ID_ALU_SUB  4'd1
`define ID_ALU_SLL  4'd2
`define ID_ALU_SLT  4'd3
`define ID_ALU_SLTU 4'd4
`define ID_ALU_XOR  4'd5
`define ID_ALU_SRL  4'd6
`define ID_ALU_SRA  4'd7
`define ID_ALU_OR   4'd8
`define ID_ALU_AND  4'd9

`endif

// ==== logic/id_pkg.sv ====
package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data word, instruction word or PC
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // ALU operation code
  typedef logic [3:0] alu_op_t;

  ////////////////////
  // Operand sources
  ////////////////////

  // Operand A from register, PC or constant zero
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_t;

  // Operand B from register or one of the immediates
  typedef enum logic [1:0] {
    OP_B_REG   = 2'd0,
    OP_B_IMM_I = 2'd1,
    OP_B_IMM_S = 2'd2,
    OP_B_IMM_U = 2'd3
  } op_b_sel_t;

  // Write-back machine
  typedef enum logic {
    WB_IDLE,
    WB_WAIT_MULTICYCLE
  } wb_state_t;

endpackage

// ==== logic/id_decoder.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module id_decoder import id_pkg::*;
(
  input  word_t     instr_i,
  input  logic      instr_valid_i,
  output alu_op_t   alu_operator_o,
  output op_a_sel_t op_a_sel_o,
  output op_b_sel_t op_b_sel_o,
  output logic      regfile_we_o,
  output logic      data_req_o,
  output logic      data_we_o,
  output logic      illegal_insn_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Raw decode before valid and illegal gating
  alu_op_t   alu_op;
  op_a_sel_t op_a_sel;
  op_b_sel_t op_b_sel;
  logic      rf_we;
  logic      mem_req;
  logic      mem_we;
  logic      illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb
  begin
    // Defaults give a register-register ADD with no side effects
    alu_op   = `ID_ALU_ADD;
    op_a_sel = OP_A_REG;
    op_b_sel = OP_B_REG;
    rf_we    = 1'b0;
    mem_req  = 1'b0;
    mem_we   = 1'b0;
    illegal  = 1'b0;

    case (opcode)
      `ID_OPC_OP:
      begin
        rf_we = 1'b1;
        case (funct3)
          `ID_F3_ADD:  alu_op = funct7[5] ? `ID_ALU_SUB : `ID_ALU_ADD;
          `ID_F3_SLL:  alu_op = `ID_ALU_SLL;
          `ID_F3_SLT:  alu_op = `ID_ALU_SLT;
          `ID_F3_SLTU: alu_op = `ID_ALU_SLTU;
          `ID_F3_XOR:  alu_op = `ID_ALU_XOR;
          `ID_F3_SR:   alu_op = funct7[5] ? `ID_ALU_SRA : `ID_ALU_SRL;
          `ID_F3_OR:   alu_op = `ID_ALU_OR;
          `ID_F3_AND:  alu_op = `ID_ALU_AND;
        endcase
        // Bit 30 only legal on SUB and SRA, other funct7 bits never
        if (funct7 == 7'b0100000)
          illegal = (funct3 != `ID_F3_ADD) && (funct3 != `ID_F3_SR);
        else if (funct7 != 7'b0000000)
          illegal = 1'b1;
      end

      `ID_OPC_OPIMM:
      begin
        rf_we    = 1'b1;
        op_b_sel = OP_B_IMM_I;
        case (funct3)
          `ID_F3_ADD:  alu_op = `ID_ALU_ADD;
          `ID_F3_SLT:  alu_op = `ID_ALU_SLT;
          `ID_F3_SLTU: alu_op = `ID_ALU_SLTU;
          `ID_F3_XOR:  alu_op = `ID_ALU_XOR;
          `ID_F3_OR:   alu_op = `ID_ALU_OR;
          `ID_F3_AND:  alu_op = `ID_ALU_AND;
          // Shift-immediate format not decoded
          default:     illegal = 1'b1;
        endcase
      end

      `ID_OPC_LUI:
      begin
        // Zero plus U immediate
        rf_we    = 1'b1;
        op_a_sel = OP_A_ZERO;
        op_b_sel = OP_B_IMM_U;
      end

      `ID_OPC_AUIPC:
      begin
        rf_we    = 1'b1;
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_IMM_U;
      end

      `ID_OPC_LOAD:
      begin
        // Address is rs1 plus I immediate
        rf_we    = 1'b1;
        mem_req  = 1'b1;
        op_b_sel = OP_B_IMM_I;
        illegal  = (funct3 != `ID_F3_WORD);
      end

      `ID_OPC_STORE:
      begin
        mem_req  = 1'b1;
        mem_we   = 1'b1;
        op_b_sel = OP_B_IMM_S;
        illegal  = (funct3 != `ID_F3_WORD);
      end

      default:
      begin
        illegal = 1'b1;
      end
    endcase
  end

  // Bubbles decode to a harmless ADD
  assign alu_operator_o = instr_valid_i ? alu_op : `ID_ALU_ADD;
  assign op_a_sel_o     = instr_valid_i ? op_a_sel : OP_A_REG;
  assign op_b_sel_o     = instr_valid_i ? op_b_sel : OP_B_REG;

  // Illegal kills write and request
  assign illegal_insn_o = instr_valid_i & illegal;
  assign regfile_we_o   = instr_valid_i & rf_we & ~illegal;
  assign data_req_o     = instr_valid_i & mem_req & ~illegal;
  assign data_we_o      = instr_valid_i & mem_we & ~illegal;

endmodule

// ==== logic/id_register_file.sv ====
`timescale 1ns/1ps

module id_register_file
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        we_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  // x1 to x31, x0 has no storage
  logic [31:0] regs_q [1:31];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (we_i && (waddr_i != 5'd0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Asynchronous, index zero reads as zero
  assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs_q[raddr_b_i];

endmodule

// ==== logic/id_operand_gen.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module id_operand_gen import id_pkg::*;
(
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  op_a_sel_t op_a_sel_i,
  input  op_b_sel_t op_b_sel_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output word_t     operand_a_o,
  output word_t     operand_b_o
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;

  // Source registers straight from the fields
  assign rf_raddr_a_o = instr_i[`ID_RS1];
  assign rf_raddr_b_o = instr_i[`ID_RS2];

  ////////////////////
  // Immediates
  ////////////////////

  // I type, sign extended from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  // S type, split field around rd position
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // U type, low 12 bits clear
  assign imm_u = {instr_i[31:12], 12'd0};

  ////////////////////
  // Operand A
  ////////////////////

  always_comb
  begin
    case (op_a_sel_i)
      OP_A_REG:  operand_a_o = rf_rdata_a_i;
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = '0;
    endcase
  end

  ////////////////////
  // Operand B
  ////////////////////

  always_comb
  begin
    case (op_b_sel_i)
      OP_B_REG:   operand_b_o = rf_rdata_b_i;
      OP_B_IMM_I: operand_b_o = imm_i;
      OP_B_IMM_S: operand_b_o = imm_s;
      OP_B_IMM_U: operand_b_o = imm_u;
      default:    operand_b_o = rf_rdata_b_i;
    endcase
  end

endmodule

// ==== logic/id_wb_fsm.sv ====
`timescale 1ns/1ps

module id_wb_fsm import id_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic regfile_we_i,
  input  logic data_req_i,
  input  logic ex_ready_i,
  output logic regfile_we_o,
  output logic select_lsu_o,
  output logic id_ready_o
);

  wb_state_t state_q;
  wb_state_t state_d;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= WB_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb
  begin
    // Single-cycle instructions pass through
    state_d      = state_q;
    regfile_we_o = regfile_we_i;
    select_lsu_o = 1'b0;
    id_ready_o   = 1'b1;

    case (state_q)
      WB_IDLE:
      begin
        // Memory access always costs at least one stall cycle
        if (data_req_i)
        begin
          regfile_we_o = 1'b0;
          id_ready_o   = 1'b0;
          state_d      = WB_WAIT_MULTICYCLE;
        end
      end

      WB_WAIT_MULTICYCLE:
      begin
        if (ex_ready_i)
        begin
          // Completion, load result comes from the LSU
          select_lsu_o = data_req_i;
          state_d      = WB_IDLE;
        end
        else
        begin
          // Held, nothing written yet
          regfile_we_o = 1'b0;
          id_ready_o   = 1'b0;
        end
      end

      default:
      begin
        state_d = WB_IDLE;
      end
    endcase
  end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module id_stage import id_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Fetch side
  input  logic    instr_valid_i,
  input  word_t   instr_i,
  input  word_t   pc_i,
  output logic    id_ready_o,
  output logic    id_valid_o,
  output logic    illegal_insn_o,
  // Execute side
  input  logic    ex_ready_i,
  input  word_t   regfile_wdata_ex_i,
  input  word_t   regfile_wdata_lsu_i,
  output alu_op_t alu_operator_o,
  output word_t   operand_a_o,
  output word_t   operand_b_o,
  output logic    data_req_o,
  output logic    data_we_o,
  output word_t   data_wdata_o
);

  // Decoder controls
  op_a_sel_t op_a_sel;
  op_b_sel_t op_b_sel;
  logic      dec_we;

  // Register file ports
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  reg_addr_t rf_waddr;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  word_t     rf_wdata;
  logic      rf_we;
  logic      select_lsu;

  ////////////////////
  // Decode
  ////////////////////

  id_decoder i_id_decoder (
    .instr_i        ( instr_i        ),
    .instr_valid_i  ( instr_valid_i  ),
    .alu_operator_o ( alu_operator_o ),
    .op_a_sel_o     ( op_a_sel       ),
    .op_b_sel_o     ( op_b_sel       ),
    .regfile_we_o   ( dec_we         ),
    .data_req_o     ( data_req_o     ),
    .data_we_o      ( data_we_o      ),
    .illegal_insn_o ( illegal_insn_o )
  );

  ////////////////////
  // Operands
  ////////////////////

  id_operand_gen i_id_operand_gen (
    .instr_i      ( instr_i     ),
    .pc_i         ( pc_i        ),
    .op_a_sel_i   ( op_a_sel    ),
    .op_b_sel_i   ( op_b_sel    ),
    .rf_rdata_a_i ( rf_rdata_a  ),
    .rf_rdata_b_i ( rf_rdata_b  ),
    .rf_raddr_a_o ( rf_raddr_a  ),
    .rf_raddr_b_o ( rf_raddr_b  ),
    .operand_a_o  ( operand_a_o ),
    .operand_b_o  ( operand_b_o )
  );

  id_register_file i_id_register_file (
    .clk       ( clk        ),
    .rst_n     ( rst_n      ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   ),
    .we_i      ( rf_we      ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b )
  );

  ////////////////////
  // Write back
  ////////////////////

  id_wb_fsm i_id_wb_fsm (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .regfile_we_i ( dec_we     ),
    .data_req_i   ( data_req_o ),
    .ex_ready_i   ( ex_ready_i ),
    .regfile_we_o ( rf_we      ),
    .select_lsu_o ( select_lsu ),
    .id_ready_o   ( id_ready_o )
  );

  // Destination and result source
  assign rf_waddr = instr_i[`ID_RD];
  assign rf_wdata = select_lsu ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

  // Store data from read port B
  assign data_wdata_o = rf_rdata_b;

  // Instruction leaves the stage
  assign id_valid_o = instr_valid_i & id_ready_o;

endmodule

// ==== bench/id_stage_properties.sv ====
`timescale 1ns/1ps

module id_stage_properties import id_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    instr_valid_i,
  input logic    id_ready_o,
  input logic    id_valid_o,
  input logic    illegal_insn_o,
  input logic    data_req_o,
  input logic    data_we_o,
  input logic    rf_we,
  input alu_op_t alu_operator_o
);

  // Memory access in flight never writes
  assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !id_ready_o |-> !rf_we)
    else $error("register write while memory access pending");

  assert property (@(posedge clk) disable iff (!rst_n) id_valid_o |-> instr_valid_i)
    else $error("id_valid_o without instr_valid_i");

  // Illegal instruction leaves the register file alone
  assert property (@(posedge clk) disable iff (!rst_n) illegal_insn_o |-> !rf_we)
    else $error("register write on illegal instruction");

  assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({id_ready_o, id_valid_o, illegal_insn_o, data_req_o, data_we_o, rf_we,
                 alu_operator_o}))
    else $error("unknown value on a control output");

endmodule

bind id_stage id_stage_properties i_id_stage_properties (.*);

// ==== bench/id_stage_tb.sv ====
`timescale 1ns/1ps

`include "id_defines.svh"

module id_stage_tb import id_pkg::*;
();

  localparam int TIMEOUT = 20;

  logic    clk;
  logic    rst_n;
  logic    instr_valid_i;
  word_t   instr_i;
  word_t   pc_i;
  logic    ex_ready_i;
  word_t   regfile_wdata_ex_i;
  word_t   regfile_wdata_lsu_i;
  logic    id_ready_o;
  logic    id_valid_o;
  logic    illegal_insn_o;
  alu_op_t alu_operator_o;
  word_t   operand_a_o;
  word_t   operand_b_o;
  logic    data_req_o;
  logic    data_we_o;
  word_t   data_wdata_o;

  // Expected register contents
  word_t       regs_model [32];
  int          errors;
  int          checks;
  int          tests_run;

  id_stage i_id_stage (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////
  // Execute model
  ////////////////////

  function automatic word_t alu_result(alu_op_t op, word_t a, word_t b);
    case (op)
      `ID_ALU_ADD:  return a + b;
      `ID_ALU_SUB:  return a - b;
      `ID_ALU_SLL:  return a << b[4:0];
      `ID_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `ID_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `ID_ALU_XOR:  return a ^ b;
      `ID_ALU_SRL:  return a >> b[4:0];
      `ID_ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      `ID_ALU_OR:   return a | b;
      `ID_ALU_AND:  return a & b;
      default:      return '0;
    endcase
  endfunction

  // ALU result back within the same cycle
  assign regfile_wdata_ex_i = alu_result(alu_operator_o, operand_a_o, operand_b_o);

  ////////////////////
  // Encoders
  ////////////////////

  function automatic word_t r_type_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                        logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `ID_OPC_OP};
  endfunction

  function automatic word_t i_type_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                        reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, `ID_F3_WORD, imm[4:0], `ID_OPC_STORE};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t rand_word();
    return $urandom;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_op(string name, alu_op_t got, alu_op_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(string name, int err_before);
    tests_run++;
    $display("Test %s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  task automatic finish_run();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  ////////////////////
  // Fetch side
  ////////////////////

  // Present an instruction and return at the falling edge
  task automatic start_instr(word_t ins, word_t pc_val);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= ins;
    pc_i          <= pc_val;
    @(negedge clk);
  endtask

  // Called at a falling edge
  task automatic wait_ready(string what);
    int cycles;
    cycles = 0;
    while (id_ready_o !== 1'b1 && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (id_ready_o !== 1'b1)
    begin
      $display("Timeout at %0t: %s never completed", $time, what);
      errors++;
      finish_run();
    end
  endtask

  // Completing edge followed by a bubble
  task automatic complete_instr(string what);
    wait_ready(what);
    @(posedge clk);
    instr_valid_i <= 1'b0;
    ex_ready_i    <= 1'b0;
  endtask

  // ADD x0, r, x0 shows the register on operand A
  task automatic read_reg(reg_addr_t r, output word_t val);
    start_instr(r_type_word(7'd0, 5'd0, r, `ID_F3_ADD, 5'd0), '0);
    val = operand_a_o;
    complete_instr("register read");
  endtask

  // LUI then ADDI with the upper part rounded for the signed low part
  task automatic load_const(reg_addr_t rd, word_t v);
    logic [19:0] upper;
    upper = v[31:12] + {19'd0, v[11]};
    start_instr({upper, rd, `ID_OPC_LUI}, '0);
    complete_instr("LUI");
    start_instr(i_type_word(v[11:0], rd, `ID_F3_ADD, rd, `ID_OPC_OPIMM), '0);
    complete_instr("ADDI");
    if (rd != 5'd0)
      regs_model[rd] = v;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_outputs();
    int    e;
    word_t val;
    e = errors;
    @(negedge clk);
    check_bit("data_req_o", data_req_o, 1'b0);
    check_bit("id_valid_o", id_valid_o, 1'b0);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
    // Untouched register still cleared
    read_reg(5'd31, val);
    check_word("x31 after reset", val, '0);
    report_test("reset state", e);
  endtask

  task automatic immediate_alu();
    int          e;
    logic [2:0]  f3 [3];
    alu_op_t     ops [3];
    logic [11:0] imm;
    reg_addr_t   rd;
    word_t       w;
    e = errors;
    f3  = '{`ID_F3_ADD, `ID_F3_XOR, `ID_F3_SLT};
    ops = '{`ID_ALU_ADD, `ID_ALU_XOR, `ID_ALU_SLT};
    for (int k = 0; k < 3; k++)
    begin
      w   = rand_word();
      imm = w[11:0];
      rd  = reg_addr_t'(6 + k);
      start_instr(i_type_word(imm, 5'd0, f3[k], rd, `ID_OPC_OPIMM), '0);
      check_word("operand_a_o", operand_a_o, '0);
      check_word("operand_b_o", operand_b_o, sext12(imm));
      check_op("alu_operator_o", alu_operator_o, ops[k]);
      check_bit("id_ready_o", id_ready_o, 1'b1);
      check_bit("id_valid_o", id_valid_o, 1'b1);
      check_bit("illegal_insn_o", illegal_insn_o, 1'b0);
      complete_instr("immediate ALU op");
      regs_model[rd] = alu_result(ops[k], '0, sext12(imm));
    end
    report_test("immediate ALU", e);
  endtask

  task automatic register_readback();
    int        e;
    logic [6:0] f7 [3];
    logic [2:0] f3 [3];
    alu_op_t   ops [3];
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     val;
    e = errors;
    f7  = '{7'b0000000, 7'b0100000, 7'b0000000};
    f3  = '{`ID_F3_ADD, `ID_F3_ADD, `ID_F3_AND};
    ops = '{`ID_ALU_ADD, `ID_ALU_SUB, `ID_ALU_AND};
    for (int r = 1; r <= 5; r++)
      load_const(reg_addr_t'(r), rand_word());
    for (int k = 0; k < 3; k++)
    begin
      rs1 = reg_addr_t'(1 + rand_word() % 5);
      rs2 = reg_addr_t'(1 + rand_word() % 5);
      rd  = reg_addr_t'(10 + k);
      start_instr(r_type_word(f7[k], rs2, rs1, f3[k], rd), '0);
      check_word("operand_a_o", operand_a_o, regs_model[rs1]);
      check_word("operand_b_o", operand_b_o, regs_model[rs2]);
      check_op("alu_operator_o", alu_operator_o, ops[k]);
      check_bit("id_ready_o", id_ready_o, 1'b1);
      complete_instr("register ALU op");
      regs_model[rd] = alu_result(ops[k], regs_model[rs1], regs_model[rs2]);
      read_reg(rd, val);
      check_word("register readback", val, regs_model[rd]);
    end
    // x0 keeps reading zero after a write
    start_instr(i_type_word(12'h123, 5'd1, `ID_F3_ADD, 5'd0, `ID_OPC_OPIMM), '0);
    complete_instr("write to x0");
    read_reg(5'd0, val);
    check_word("x0 readback", val, '0);
    report_test("register write and readback", e);
  endtask

  task automatic upper_immediates();
    int    e;
    word_t w;
    word_t pc_val;
    e = errors;
    w = rand_word();
    start_instr({w[31:12], 5'd20, `ID_OPC_LUI}, '0);
    check_word("operand_a_o", operand_a_o, '0);
    check_word("operand_b_o", operand_b_o, {w[31:12], 12'd0});
    check_op("alu_operator_o", alu_operator_o, `ID_ALU_ADD);
    complete_instr("LUI");
    regs_model[20] = {w[31:12], 12'd0};
    w      = rand_word();
    pc_val = rand_word() & ~32'd3;
    start_instr({w[31:12], 5'd21, `ID_OPC_AUIPC}, pc_val);
    check_word("operand_a_o", operand_a_o, pc_val);
    check_word("operand_b_o", operand_b_o, {w[31:12], 12'd0});
    complete_instr("AUIPC");
    regs_model[21] = pc_val + {w[31:12], 12'd0};
    report_test("LUI and AUIPC", e);
  endtask

  task automatic stalled_loads();
    int          e;
    int          stall;
    logic [11:0] imm;
    reg_addr_t   rd;
    word_t       w;
    word_t       val;
    e = errors;
    for (int k = 0; k < 3; k++)
    begin
      w     = rand_word();
      imm   = w[11:0];
      rd    = reg_addr_t'(22 + k);
      stall = rand_word() % 5;
      regfile_wdata_lsu_i <= rand_word();
      start_instr(i_type_word(imm, 5'd1, `ID_F3_WORD, rd, `ID_OPC_LOAD), '0);
      check_bit("data_req_o", data_req_o, 1'b1);
      check_bit("data_we_o", data_we_o, 1'b0);
      check_bit("id_ready_o", id_ready_o, 1'b0);
      check_bit("id_valid_o", id_valid_o, 1'b0);
      check_word("operand_a_o", operand_a_o, regs_model[1]);
      check_word("operand_b_o", operand_b_o, sext12(imm));
      for (int s = 0; s < stall; s++)
      begin
        @(negedge clk);
        check_bit("data_req_o", data_req_o, 1'b1);
        check_bit("id_ready_o", id_ready_o, 1'b0);
        check_bit("id_valid_o", id_valid_o, 1'b0);
      end
      @(posedge clk);
      ex_ready_i <= 1'b1;
      @(negedge clk);
      regs_model[rd] = regfile_wdata_lsu_i;
      complete_instr("load");
      read_reg(rd, val);
      check_word("load readback", val, regs_model[rd]);
    end
    report_test("loads with stalls", e);
  endtask

  task automatic word_stores();
    int          e;
    logic [11:0] imm;
    word_t       w;
    word_t       val;
    e = errors;
    // rd field points at x10 so a stray write would show
    w   = rand_word();
    imm = {w[6:0], 5'd10};
    start_instr(s_type_word(imm, 5'd2, 5'd1), '0);
    check_bit("data_req_o", data_req_o, 1'b1);
    check_bit("data_we_o", data_we_o, 1'b1);
    check_word("data_wdata_o", data_wdata_o, regs_model[2]);
    check_word("operand_a_o", operand_a_o, regs_model[1]);
    check_word("operand_b_o", operand_b_o, sext12(imm));
    @(posedge clk);
    ex_ready_i <= 1'b1;
    @(negedge clk);
    complete_instr("store");
    read_reg(5'd10, val);
    check_word("x10 after store", val, regs_model[10]);
    report_test("stores", e);
  endtask

  task automatic illegal_decode();
    int    e;
    word_t val;
    e = errors;
    // Undefined opcode
    start_instr(i_type_word(12'h5a5, 5'd1, 3'b000, 5'd3, 7'b1111111), '0);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b1);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    check_bit("data_req_o", data_req_o, 1'b0);
    complete_instr("undefined opcode");
    read_reg(5'd3, val);
    check_word("x3 after illegal", val, regs_model[3]);
    // Byte load is not decoded
    start_instr(i_type_word(12'h004, 5'd1, 3'b000, 5'd4, `ID_OPC_LOAD), '0);
    check_bit("illegal_insn_o", illegal_insn_o, 1'b1);
    check_bit("id_ready_o", id_ready_o, 1'b1);
    check_bit("data_req_o", data_req_o, 1'b0);
    complete_instr("byte load");
    read_reg(5'd4, val);
    check_word("x4 after illegal", val, regs_model[4]);
    report_test("illegal instructions", e);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    void'($urandom(32'h4b4e2a53));
    errors              = 0;
    checks              = 0;
    tests_run           = 0;
    rst_n               = 1'b0;
    instr_valid_i       = 1'b0;
    instr_i             = '0;
    pc_i                = '0;
    ex_ready_i          = 1'b0;
    regfile_wdata_lsu_i = '0;
    for (int r = 0; r < 32; r++)
      regs_model[r] = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_outputs();
    immediate_alu();
    register_readback();
    upper_immediates();
    stalled_loads();
    word_stores();
    illegal_decode();
    finish_run();
  end

endmodule

// ==== id_stage.f ====
+incdir+logic
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_register_file.sv
logic/id_operand_gen.sv
logic/id_wb_fsm.sv
logic/id_stage.sv
bench/id_stage_properties.sv
bench/id_stage_tb.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/id_pkg.sv
      - logic/id_decoder.sv
      - logic/id_register_file.sv
      - logic/id_operand_gen.sv
      - logic/id_wb_fsm.sv
      - logic/id_stage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/id_stage_properties.sv
      - bench/id_stage_tb.sv
